// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 32;
	localparam int MUL_LATENCY = 2;
	localparam int MUL_CNT_W = $clog2(MUL_LATENCY + 1);

	typedef logic [XLEN-1:0] word_t;
	typedef logic [7:0] tag_t; // Tag 0 is the reset value.
	typedef logic [4:0] reg_idx_t;
	typedef logic [2:0] mem_width_t; // Bytes per access, 0 for none.

	// RV32 major opcodes.
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
		ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_t;

	typedef enum logic [3:0] {
		CLS_ALU, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_LUI, CLS_AUIPC,
		CLS_LOAD, CLS_STORE, CLS_MUL, CLS_DIV, CLS_ILLEGAL
	} op_class_t;

	// Order follows funct3[1:0].
	typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_t;
	typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_t;

	typedef struct packed {
		tag_t tag;
		word_t pc;
		word_t instruction;
		word_t rs1;
		word_t rs2;
	} exec_req_t;

	typedef struct packed {
		op_class_t cls;
		alu_op_t alu_op;
		mul_op_t mul_op;
		div_op_t div_op;
		word_t imm;
		reg_idx_t rd;
		mem_width_t mem_width;
		logic mem_signed;
	} decoded_t;

	typedef struct packed {
		tag_t tag;
		reg_idx_t rd;
		word_t rd_value;
		logic branch_taken;
		word_t pc_next;
		logic mem_read;
		logic mem_write;
		mem_width_t mem_width;
		logic mem_signed;
		word_t mem_address;
		logic illegal;
	} exec_result_t;

endpackage

`default_nettype wire

// ==== source/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
	input wire cpu_pkg::word_t i_instruction,
	output cpu_pkg::decoded_t o_dec
);
	import cpu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	mem_width_t access_width;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];

	assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
	assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
	assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
		i_instruction[30:25], i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'b0};
	assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
		i_instruction[20], i_instruction[30:21], 1'b0};

	assign access_width = mem_width_t'(3'd1 << funct3[1:0]); // 1, 2 or 4 bytes.

	function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? ALU_SUB : ALU_ADD;
			3'b001: return ALU_SLL;
			3'b010: return ALU_SLT;
			3'b011: return ALU_SLTU;
			3'b100: return ALU_XOR;
			3'b101: return alt ? ALU_SRA : ALU_SRL;
			3'b110: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		o_dec = '0;
		o_dec.cls = CLS_ILLEGAL;
		o_dec.rd = i_instruction[11:7];
		case (opcode)
			OPC_LUI: begin
				o_dec.cls = CLS_LUI;
				o_dec.imm = imm_u;
			end
			OPC_AUIPC: begin
				o_dec.cls = CLS_AUIPC;
				o_dec.imm = imm_u;
			end
			OPC_JAL: begin
				o_dec.cls = CLS_JAL;
				o_dec.imm = imm_j;
			end
			OPC_JALR: begin
				o_dec.imm = imm_i;
				if (funct3 == 3'b000)
					o_dec.cls = CLS_JALR;
			end
			OPC_BRANCH: begin
				o_dec.imm = imm_b;
				o_dec.cls = CLS_BRANCH;
				case (funct3)
					3'b000: o_dec.alu_op = ALU_EQ;
					3'b001: o_dec.alu_op = ALU_NE;
					3'b100: o_dec.alu_op = ALU_LT;
					3'b101: o_dec.alu_op = ALU_GE;
					3'b110: o_dec.alu_op = ALU_LTU;
					3'b111: o_dec.alu_op = ALU_GEU;
					default: o_dec.cls = CLS_ILLEGAL;
				endcase
			end
			OPC_LOAD: begin
				o_dec.imm = imm_i;
				if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
					o_dec.cls = CLS_LOAD;
					o_dec.mem_width = access_width;
					o_dec.mem_signed = !funct3[2] && funct3[1:0] != 2'b10; // lw is unsigned.
				end
			end
			OPC_STORE: begin
				o_dec.imm = imm_s;
				if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
					o_dec.cls = CLS_STORE;
					o_dec.mem_width = access_width;
				end
			end
			OPC_OP_IMM: begin
				o_dec.imm = imm_i;
				o_dec.alu_op = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
				if ((funct3 != 3'b001 && funct3 != 3'b101) ||
						funct7 == 7'b0000000 ||
						(funct3 == 3'b101 && funct7 == 7'b0100000))
					o_dec.cls = CLS_ALU;
			end
			OPC_OP: begin
				o_dec.alu_op = alu_from_funct(funct3, funct7[5]);
				o_dec.mul_op = mul_op_t'(funct3[1:0]);
				o_dec.div_op = div_op_t'(funct3[1:0]);
				if (funct7 == 7'b0000001)
					o_dec.cls = funct3[2] ? CLS_DIV : CLS_MUL;
				else if (funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
					o_dec.cls = CLS_ALU;
			end
			default: ; // Fence, system and unknown opcodes stay illegal.
		endcase
		if (o_dec.cls inside {CLS_BRANCH, CLS_STORE, CLS_ILLEGAL})
			o_dec.rd = '0; // No register write.
	end

endmodule

`default_nettype wire

// ==== source/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
	input wire cpu_pkg::alu_op_t i_op,
	input wire cpu_pkg::word_t i_op1,
	input wire cpu_pkg::word_t i_op2,
	output cpu_pkg::word_t o_result
);
	import cpu_pkg::*;

	logic [4:0] shamt;
	logic equal;
	logic signed_lt;
	logic unsigned_lt;

	assign shamt = i_op2[4:0];
	assign equal = (i_op1 == i_op2);
	assign signed_lt = ($signed(i_op1) < $signed(i_op2));
	assign unsigned_lt = (i_op1 < i_op2);

	// Compares return 1 or 0 in the low bit.
	always_comb begin
		case (i_op)
			ALU_ADD:  o_result = i_op1 + i_op2;
			ALU_SUB:  o_result = i_op1 - i_op2;
			ALU_SLL:  o_result = i_op1 << shamt;
			ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, signed_lt};
			ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, unsigned_lt};
			ALU_XOR:  o_result = i_op1 ^ i_op2;
			ALU_SRL:  o_result = i_op1 >> shamt;
			ALU_SRA:  o_result = $signed(i_op1) >>> shamt;
			ALU_OR:   o_result = i_op1 | i_op2;
			ALU_AND:  o_result = i_op1 & i_op2;
			ALU_EQ:   o_result = {{(XLEN-1){1'b0}}, equal};
			ALU_NE:   o_result = {{(XLEN-1){1'b0}}, !equal};
			ALU_LT:   o_result = {{(XLEN-1){1'b0}}, signed_lt};
			ALU_GE:   o_result = {{(XLEN-1){1'b0}}, !signed_lt};
			ALU_LTU:  o_result = {{(XLEN-1){1'b0}}, unsigned_lt};
			ALU_GEU:  o_result = {{(XLEN-1){1'b0}}, !unsigned_lt};
			default:  o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/cpu_multiply.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_multiply (
	input wire i_clock,
	input wire i_rst_n,
	input wire cpu_pkg::mul_op_t i_op,
	input wire cpu_pkg::word_t i_op1,
	input wire cpu_pkg::word_t i_op2,
	output cpu_pkg::word_t o_result
);
	import cpu_pkg::*;

	logic op1_signed;
	logic op2_signed;
	logic signed [XLEN:0] op1_q, op2_q;
	logic signed [2*XLEN+1:0] product_q;
	mul_op_t op_q1, op_q2;

	// Only mulh and mulhsu treat rs1 as signed, only mulh treats rs2 as signed.
	assign op1_signed = (i_op == MUL_MULH) || (i_op == MUL_MULHSU);
	assign op2_signed = (i_op == MUL_MULH);

	always_ff @(posedge i_clock) begin
		op1_q <= {op1_signed & i_op1[XLEN-1], i_op1};
		op2_q <= {op2_signed & i_op2[XLEN-1], i_op2};
		product_q <= op1_q * op2_q;
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			op_q1 <= MUL_MUL;
			op_q2 <= MUL_MUL;
		end else begin
			op_q1 <= i_op;
			op_q2 <= op_q1; // Travels alongside the product.
		end
	end

	assign o_result = (op_q2 == MUL_MUL) ? product_q[XLEN-1:0] : product_q[2*XLEN-1:XLEN];

	a_op_known: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!$isunknown(op_q2));

endmodule

`default_nettype wire

// ==== source/cpu_divide.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_divide (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_start,
	input wire cpu_pkg::div_op_t i_op,
	input wire cpu_pkg::word_t i_numerator,
	input wire cpu_pkg::word_t i_denominator,
	output logic o_busy,
	output logic o_done,
	output cpu_pkg::word_t o_result
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_FIX, ST_DONE} state_t;

	state_t state;
	logic [$clog2(XLEN)-1:0] count;
	div_op_t op_q;
	word_t numerator_q, divisor_q, quotient_q, remainder_q, result_q;
	logic neg_quotient, neg_remainder;
	logic is_signed;
	word_t num_mag, den_mag;
	logic [XLEN:0] shifted, diff;

	assign is_signed = (i_op == DIV_DIV) || (i_op == DIV_REM);
	assign num_mag = (is_signed && i_numerator[XLEN-1]) ? -i_numerator : i_numerator;
	assign den_mag = (is_signed && i_denominator[XLEN-1]) ? -i_denominator : i_denominator;

	// One restoring step per cycle.
	assign shifted = {remainder_q, quotient_q[XLEN-1]};
	assign diff = shifted - {1'b0, divisor_q};

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			count <= '0;
		end else begin
			case (state)
				ST_IDLE: if (i_start) begin
					state <= ST_RUN;
					count <= '0;
				end
				ST_RUN: begin
					count <= count + 1'b1;
					if (count == $clog2(XLEN)'(XLEN - 1))
						state <= ST_FIX;
				end
				ST_FIX:  state <= ST_DONE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE && i_start) begin
			op_q <= i_op;
			numerator_q <= i_numerator;
			divisor_q <= den_mag;
			quotient_q <= num_mag; // Dividend shifts out as quotient shifts in.
			remainder_q <= '0;
			neg_quotient <= is_signed && (i_numerator[XLEN-1] ^ i_denominator[XLEN-1]);
			neg_remainder <= is_signed && i_numerator[XLEN-1];
		end else if (state == ST_RUN) begin
			remainder_q <= diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
			quotient_q <= {quotient_q[XLEN-2:0], !diff[XLEN]};
		end else if (state == ST_FIX) begin
			// Most negative over -1 already yields itself and a zero remainder.
			if (divisor_q == '0)
				result_q <= (op_q == DIV_DIV || op_q == DIV_DIVU) ? '1 : numerator_q;
			else if (op_q == DIV_DIV || op_q == DIV_DIVU)
				result_q <= neg_quotient ? -quotient_q : quotient_q;
			else
				result_q <= neg_remainder ? -remainder_q : remainder_q;
		end
	end

	assign o_busy = (state != ST_IDLE);
	assign o_done = (state == ST_DONE);
	assign o_result = result_q;

	a_no_restart: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_start |-> !o_busy);

endmodule

`default_nettype wire

// ==== source/cpu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_stall,
	input wire cpu_pkg::exec_req_t i_req,
	input wire cpu_pkg::decoded_t i_dec,
	output cpu_pkg::exec_result_t o_result,
	output logic o_stall
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_MUL, ST_DIV} state_t;

	state_t state;
	logic [MUL_CNT_W-1:0] mul_count;
	logic new_req;
	logic div_start, div_busy, div_done, div_seen;
	word_t alu_op2, alu_result, mul_result, div_result;
	word_t pc_plus_4, pc_plus_imm, rs1_plus_imm;
	exec_result_t single_res, multi_res;

	assign new_req = (i_req.tag != o_result.tag); // Tag mismatch marks a new request.
	assign alu_op2 = (i_req.instruction[6:0] == OPC_OP_IMM) ? i_dec.imm : i_req.rs2;
	assign pc_plus_4 = i_req.pc + 32'd4;
	assign pc_plus_imm = i_req.pc + i_dec.imm;
	assign rs1_plus_imm = i_req.rs1 + i_dec.imm;
	assign div_start = !i_stall && state == ST_IDLE && new_req && i_dec.cls == CLS_DIV;

	cpu_alu cpu_alu_i (
		.i_op(i_dec.alu_op),
		.i_op1(i_req.rs1),
		.i_op2(alu_op2),
		.o_result(alu_result)
	);

	// Operands come straight from the held request.
	cpu_multiply cpu_multiply_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_op(i_dec.mul_op),
		.i_op1(i_req.rs1),
		.i_op2(i_req.rs2),
		.o_result(mul_result)
	);

	cpu_divide cpu_divide_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_start(div_start),
		.i_op(i_dec.div_op),
		.i_numerator(i_req.rs1),
		.i_denominator(i_req.rs2),
		.o_busy(div_busy),
		.o_done(div_done),
		.o_result(div_result)
	);

	always_comb begin
		single_res = '0;
		single_res.tag = i_req.tag;
		single_res.rd = i_dec.rd;
		single_res.pc_next = pc_plus_4;
		case (i_dec.cls)
			CLS_ALU: single_res.rd_value = alu_result;
			CLS_BRANCH: begin
				single_res.branch_taken = alu_result[0];
				if (alu_result[0])
					single_res.pc_next = pc_plus_imm;
			end
			CLS_JAL, CLS_JALR: begin
				single_res.rd_value = pc_plus_4; // Link value.
				single_res.branch_taken = 1'b1;
				single_res.pc_next = (i_dec.cls == CLS_JAL) ? pc_plus_imm :
					{rs1_plus_imm[XLEN-1:1], 1'b0};
			end
			CLS_LUI:   single_res.rd_value = i_dec.imm;
			CLS_AUIPC: single_res.rd_value = pc_plus_imm;
			CLS_LOAD, CLS_STORE: begin
				single_res.mem_read = (i_dec.cls == CLS_LOAD);
				single_res.mem_write = (i_dec.cls == CLS_STORE);
				single_res.mem_width = i_dec.mem_width;
				single_res.mem_signed = i_dec.mem_signed;
				single_res.mem_address = rs1_plus_imm;
				if (i_dec.cls == CLS_STORE)
					single_res.rd_value = i_req.rs2; // Store data.
			end
			default: single_res.illegal = 1'b1; // Mul and div never take this path.
		endcase
	end

	always_comb begin
		multi_res = '0;
		multi_res.tag = i_req.tag;
		multi_res.rd = i_dec.rd;
		multi_res.rd_value = (state == ST_MUL) ? mul_result : div_result;
		multi_res.pc_next = pc_plus_4;
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			mul_count <= '0;
			div_seen <= 1'b0;
			o_result <= '0;
		end else begin
			if (div_done)
				div_seen <= 1'b1; // Keep a done pulse that lands in a stall.
			if (!i_stall) begin
				case (state)
					ST_IDLE: if (new_req) begin
						case (i_dec.cls)
							CLS_MUL: begin
								state <= ST_MUL;
								mul_count <= '0;
							end
							CLS_DIV: state <= ST_DIV;
							default: o_result <= single_res;
						endcase
					end
					ST_MUL: begin
						if (mul_count == MUL_CNT_W'(MUL_LATENCY)) begin
							o_result <= multi_res;
							state <= ST_IDLE;
						end else begin
							mul_count <= mul_count + 1'b1;
						end
					end
					ST_DIV: if (div_done || div_seen) begin
						o_result <= multi_res;
						div_seen <= 1'b0;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	assign o_stall = (state != ST_IDLE);

	a_mem_exclusive: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(o_result.mem_read && o_result.mem_write));

	// Divider stays busy until its result has been seen.
	a_div_tracks: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(state == ST_DIV && !div_seen) |-> div_busy);

endmodule

`default_nettype wire

// ==== source/cpu_execute_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_execute_top (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_stall,
	input wire cpu_pkg::exec_req_t i_req,
	output cpu_pkg::exec_result_t o_result,
	output logic o_stall
);
	import cpu_pkg::*;

	decoded_t dec;

	cpu_decode cpu_decode_i (
		.i_instruction(i_req.instruction),
		.o_dec(dec)
	);

	cpu_execute cpu_execute_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_stall(i_stall),
		.i_req(i_req),
		.i_dec(dec),
		.o_result(o_result),
		.o_stall(o_stall)
	);

endmodule

`default_nettype wire

// ==== dv/execute_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_checker (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_stall,
	input wire i_busy,
	input wire cpu_pkg::exec_req_t i_req,
	input wire cpu_pkg::exec_result_t i_result,
	output int o_error_count
);
	import cpu_pkg::*;

	exec_req_t req_q;
	tag_t last_tag;
	logic pending;
	logic accepted;
	logic multi_cycle;
	logic prev_stall;
	logic reset_checked;
	int errors = 0;

	assign o_error_count = errors;

	function automatic word_t integer_op(input logic [2:0] f3, input logic alt,
			input word_t a, input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// RV32M semantics, including divide by zero and signed overflow.
	function automatic word_t muldiv_op(input logic [2:0] f3, input word_t a, input word_t b);
		logic [63:0] ext_a;
		logic [63:0] ext_b;
		logic [63:0] product;
		logic overflow;
		ext_a = (f3 == 3'd1 || f3 == 3'd2) ? {{32{a[31]}}, a} : {32'b0, a};
		ext_b = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'b0, b};
		product = ext_a * ext_b; // Low 64 bits are exact for every sign mix.
		overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (f3)
			3'd0: return product[31:0];
			3'd1, 3'd2, 3'd3: return product[63:32];
			3'd4: begin
				if (b == '0)
					return '1;
				if (overflow)
					return a;
				return $signed(a) / $signed(b);
			end
			3'd5: return (b == '0) ? '1 : a / b;
			3'd6: begin
				if (b == '0)
					return a;
				if (overflow)
					return '0;
				return $signed(a) % $signed(b);
			end
			default: return (b == '0) ? a : a % b;
		endcase
	endfunction

	function automatic exec_result_t expected_result(input exec_req_t r);
		exec_result_t e;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		word_t imm_i, imm_s, imm_b, imm_u, imm_j;
		logic legal;
		opc = r.instruction[6:0];
		f3 = r.instruction[14:12];
		f7 = r.instruction[31:25];
		imm_i = {{20{r.instruction[31]}}, r.instruction[31:20]};
		imm_s = {{20{r.instruction[31]}}, r.instruction[31:25], r.instruction[11:7]};
		imm_b = {{20{r.instruction[31]}}, r.instruction[7], r.instruction[30:25],
			r.instruction[11:8], 1'b0};
		imm_u = {r.instruction[31:12], 12'b0};
		imm_j = {{12{r.instruction[31]}}, r.instruction[19:12], r.instruction[20],
			r.instruction[30:21], 1'b0};
		e = '0;
		e.tag = r.tag;
		e.rd = r.instruction[11:7];
		e.pc_next = r.pc + 32'd4;
		legal = 1'b1;
		case (opc)
			OPC_LUI:   e.rd_value = imm_u;
			OPC_AUIPC: e.rd_value = r.pc + imm_u;
			OPC_JAL: begin
				e.rd_value = r.pc + 32'd4;
				e.branch_taken = 1'b1;
				e.pc_next = r.pc + imm_j;
			end
			OPC_JALR: begin
				legal = (f3 == 3'd0);
				e.rd_value = r.pc + 32'd4;
				e.branch_taken = 1'b1;
				e.pc_next = (r.rs1 + imm_i) & ~32'd1;
			end
			OPC_BRANCH: begin
				e.rd = '0;
				case (f3)
					3'd0: e.branch_taken = (r.rs1 == r.rs2);
					3'd1: e.branch_taken = (r.rs1 != r.rs2);
					3'd4: e.branch_taken = ($signed(r.rs1) < $signed(r.rs2));
					3'd5: e.branch_taken = ($signed(r.rs1) >= $signed(r.rs2));
					3'd6: e.branch_taken = (r.rs1 < r.rs2);
					3'd7: e.branch_taken = (r.rs1 >= r.rs2);
					default: legal = 1'b0;
				endcase
				if (e.branch_taken)
					e.pc_next = r.pc + imm_b;
			end
			OPC_LOAD: begin
				legal = (f3 != 3'd3) && (f3 < 3'd6); // lb, lh, lw, lbu, lhu.
				e.mem_read = 1'b1;
				e.mem_width = (f3[1:0] == 2'd0) ? 3'd1 : (f3[1:0] == 2'd1) ? 3'd2 : 3'd4;
				e.mem_signed = (f3 == 3'd0) || (f3 == 3'd1);
				e.mem_address = r.rs1 + imm_i;
			end
			OPC_STORE: begin
				legal = (f3 < 3'd3);
				e.rd = '0;
				e.mem_write = 1'b1;
				e.mem_width = (f3[1:0] == 2'd0) ? 3'd1 : (f3[1:0] == 2'd1) ? 3'd2 : 3'd4;
				e.mem_address = r.rs1 + imm_s;
				e.rd_value = r.rs2;
			end
			OPC_OP_IMM: begin
				if (f3 == 3'd1)
					legal = (f7 == 7'h00);
				else if (f3 == 3'd5)
					legal = (f7 == 7'h00) || (f7 == 7'h20);
				e.rd_value = integer_op(f3, f3 == 3'd5 && f7[5], r.rs1, imm_i);
			end
			OPC_OP: begin
				if (f7 == 7'h01)
					e.rd_value = muldiv_op(f3, r.rs1, r.rs2);
				else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
					e.rd_value = integer_op(f3, f7[5], r.rs1, r.rs2);
				else
					legal = 1'b0;
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			e = '0;
			e.tag = r.tag;
			e.pc_next = r.pc + 32'd4;
			e.illegal = 1'b1;
		end
		return e;
	endfunction

	task automatic check_field(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_result(input exec_result_t e, input exec_result_t a);
		check_field("o_result.tag", word_t'(e.tag), word_t'(a.tag));
		check_field("o_result.rd", word_t'(e.rd), word_t'(a.rd));
		check_field("o_result.rd_value", e.rd_value, a.rd_value);
		check_field("o_result.branch_taken", word_t'(e.branch_taken), word_t'(a.branch_taken));
		check_field("o_result.pc_next", e.pc_next, a.pc_next);
		check_field("o_result.mem_read", word_t'(e.mem_read), word_t'(a.mem_read));
		check_field("o_result.mem_write", word_t'(e.mem_write), word_t'(a.mem_write));
		check_field("o_result.mem_width", word_t'(e.mem_width), word_t'(a.mem_width));
		check_field("o_result.mem_signed", word_t'(e.mem_signed), word_t'(a.mem_signed));
		check_field("o_result.mem_address", e.mem_address, a.mem_address);
		check_field("o_result.illegal", word_t'(e.illegal), word_t'(a.illegal));
	endtask

	// Outputs settle after the rising edge, so everything is sampled at the falling edge.
	always @(negedge i_clock) begin
		if (!i_rst_n) begin
			req_q = '0;
			last_tag = '0;
			pending = 1'b0;
			accepted = 1'b0;
			multi_cycle = 1'b0;
			prev_stall = 1'b0;
			reset_checked = 1'b0;
		end else begin
			if (!reset_checked) begin
				reset_checked = 1'b1;
				check_field("o_result.tag", '0, word_t'(i_result.tag));
				check_field("o_result.mem_read", '0, word_t'(i_result.mem_read));
				check_field("o_result.mem_write", '0, word_t'(i_result.mem_write));
				check_field("o_result.branch_taken", '0, word_t'(i_result.branch_taken));
				check_field("o_result.illegal", '0, word_t'(i_result.illegal));
			end
			if (i_result.tag != last_tag) begin
				if (prev_stall) begin
					errors++;
					$display("Tag %0d completed at %0t ns on an edge where i_stall was high",
						i_result.tag, $time);
				end
				if (pending && i_result.tag == req_q.tag) begin
					compare_result(expected_result(req_q), i_result);
				end else begin
					errors++;
					$display("Result tag %0d at %0t ns does not belong to the outstanding request",
						i_result.tag, $time);
				end
				pending = 1'b0;
				last_tag = i_result.tag;
			end
			// First edge with i_stall low after the request appeared.
			if (pending && !accepted && !prev_stall)
				accepted = 1'b1;
			check_field("o_stall", word_t'(pending && accepted && multi_cycle), word_t'(i_busy));
			if (i_req.tag != req_q.tag) begin
				req_q = i_req;
				pending = 1'b1;
				accepted = 1'b0;
				multi_cycle = (i_req.instruction[6:0] == OPC_OP) &&
					(i_req.instruction[31:25] == 7'h01);
			end
			prev_stall = i_stall; // Value the next rising edge will see.
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_cpu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_execute;
	import cpu_pkg::*;

	localparam int TIMEOUT_CYCLES = 100;

	logic clock;
	logic rst_n;
	logic stall;
	exec_req_t req;
	exec_result_t result;
	logic dut_stall;
	int error_count;
	int seed = 68;
	int timeouts = 0;
	int stall_left = 0;
	logic timed_out = 1'b0;
	tag_t tag = '0;

	cpu_execute_top cpu_execute_top_i (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_stall(stall),
		.i_req(req),
		.o_result(result),
		.o_stall(dut_stall)
	);

	execute_checker execute_checker_i (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_stall(stall),
		.i_busy(dut_stall),
		.i_req(req),
		.i_result(result),
		.o_error_count(error_count)
	);

	always #50 clock = ~clock;

	function automatic word_t random_word();
		return $random(seed);
	endfunction

	function automatic word_t random_pc();
		word_t w;
		w = random_word();
		return {w[31:2], 2'b00};
	endfunction

	// Register index fields come from a random fill word.
	function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
			input logic [6:0] opc, input word_t fill);
		return {f7, fill[24:15], f3, fill[11:7], opc};
	endfunction

	function automatic word_t i_type(input logic [11:0] imm, input logic [2:0] f3,
			input logic [6:0] opc, input word_t fill);
		return {imm, fill[19:15], f3, fill[11:7], opc};
	endfunction

	function automatic word_t s_type(input logic [11:0] imm, input logic [2:0] f3,
			input word_t fill);
		return {imm[11:5], fill[24:15], f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t b_type(input logic [12:0] imm, input logic [2:0] f3,
			input word_t fill);
		return {imm[12], imm[10:5], fill[24:15], f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t u_type(input logic [19:0] imm, input logic [6:0] opc,
			input word_t fill);
		return {imm, fill[11:7], opc};
	endfunction

	function automatic word_t j_type(input logic [20:0] imm, input word_t fill);
		return {imm[20], imm[10:1], imm[11], imm[19:12], fill[11:7], OPC_JAL};
	endfunction

	// Stall pulses last one to three cycles with at least one low cycle between.
	task automatic advance_cycle();
		@(posedge clock);
		#1;
		if (stall_left > 0) begin
			stall = 1'b1;
			stall_left--;
		end else if (stall) begin
			stall = 1'b0;
		end else if ((random_word() & 32'd7) == 32'd0) begin
			stall = 1'b1;
			stall_left = int'(random_word() % 32'd3);
		end
	endtask

	task automatic issue_request(input word_t pc, input word_t instruction,
			input word_t rs1, input word_t rs2);
		int cycles;
		if (!timed_out) begin
			repeat (random_word() % 32'd2)
				advance_cycle();
			tag = (tag == 8'd255) ? 8'd1 : tag + 8'd1;
			advance_cycle();
			req.tag = tag;
			req.pc = pc;
			req.instruction = instruction;
			req.rs1 = rs1;
			req.rs2 = rs2;
			cycles = 0;
			while (result.tag != tag && cycles < TIMEOUT_CYCLES) begin
				advance_cycle();
				cycles++;
			end
			if (result.tag != tag) begin
				timeouts++;
				timed_out = 1'b1;
				$display("Timeout: request with tag %0d did not complete within %0d cycles",
					tag, TIMEOUT_CYCLES);
			end
		end
	endtask

	initial begin
		word_t fill, a, b;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		int n, k, p;
		clock = 1'b0;
		rst_n = 1'b0;
		stall = 1'b0;
		req = '0;
		repeat (16) @(posedge clock);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clock);

		// Register and immediate ALU operations, then lui and auipc.
		for (n = 0; n < 150; n++) begin
			fill = random_word();
			a = random_word();
			b = random_word();
			f3 = fill[14:12];
			if (fill[31]) begin
				f7 = ((f3 == 3'd0 || f3 == 3'd5) && fill[30]) ? 7'h20 : 7'h00;
				issue_request(random_pc(), r_type(f7, f3, OPC_OP, fill), a, b);
			end else begin
				if (f3 == 3'd1)
					imm = {7'h00, fill[24:20]};
				else if (f3 == 3'd5)
					imm = {(fill[30] ? 7'h20 : 7'h00), fill[24:20]};
				else
					imm = b[11:0];
				issue_request(random_pc(), i_type(imm, f3, OPC_OP_IMM, fill), a, b);
			end
		end
		for (n = 0; n < 20; n++) begin
			fill = random_word();
			a = random_word();
			issue_request(random_pc(), u_type(a[31:12], n[0] ? OPC_AUIPC : OPC_LUI, fill),
				random_word(), random_word());
		end

		// Every branch funct3 with equal, less and greater pairs.
		for (k = 0; k < 8; k++) begin
			for (p = 0; p < 4; p++) begin
				fill = random_word();
				a = random_word();
				case (p)
					0: b = a;
					1: b = a + 32'd1;
					2: b = a - 32'd1;
					default: begin
						a = 32'hffff_fff0; // Less when signed, greater when unsigned.
						b = 32'd16;
					end
				endcase
				issue_request(random_pc(), b_type({fill[12:1], 1'b0}, k[2:0], fill), a, b);
				issue_request(random_pc(), b_type({fill[12:1], 1'b0}, k[2:0], fill), b, a);
			end
		end
		for (n = 0; n < 20; n++) begin
			fill = random_word();
			a = random_word();
			if (n[0])
				issue_request(random_pc(), j_type({fill[20:1], 1'b0}, fill), a, random_word());
			else
				issue_request(random_pc(), i_type(fill[31:20], 3'd0, OPC_JALR, fill), a, a);
		end

		// Loads and stores of every width, invalid funct3 included.
		for (k = 0; k < 8; k++) begin
			for (n = 0; n < 3; n++) begin
				fill = random_word();
				a = random_word();
				b = random_word();
				issue_request(random_pc(), i_type(fill[31:20], k[2:0], OPC_LOAD, fill), a, b);
				if (k < 4)
					issue_request(random_pc(), s_type(fill[31:20], k[2:0], fill), a, b);
			end
		end

		// Multiply and divide with random, zero and overflow operands.
		for (k = 0; k < 8; k++) begin
			for (n = 0; n < 7; n++) begin
				fill = random_word();
				a = random_word();
				b = random_word();
				if (n == 5) begin
					b = 32'd0;
				end else if (n == 6) begin
					a = 32'h8000_0000;
					b = 32'hffff_ffff;
				end
				issue_request(random_pc(), r_type(7'h01, k[2:0], OPC_OP, fill), a, b);
			end
		end

		// Fence, system, CSR, unknown opcodes and bad funct7.
		issue_request(random_pc(), 32'h0000_000f, random_word(), random_word());
		issue_request(random_pc(), 32'h0000_0073, random_word(), random_word());
		issue_request(random_pc(), 32'h0010_0073, random_word(), random_word());
		issue_request(random_pc(), 32'h3000_1073, random_word(), random_word());
		issue_request(random_pc(), 32'h0000_0000, random_word(), random_word());
		for (n = 0; n < 6; n++) begin
			fill = random_word();
			issue_request(random_pc(), r_type(7'h40, fill[14:12], OPC_OP, fill),
				random_word(), random_word());
			issue_request(random_pc(), {fill[31:7], 7'b1011011}, random_word(), random_word());
			issue_request(random_pc(), i_type(fill[31:20], 3'd1, OPC_JALR, fill),
				random_word(), random_word());
		end

		repeat (3) @(posedge clock);
		$display("Errors: %0d, timeouts: %0d", error_count, timeouts);
		if (error_count == 0 && timeouts == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
source/cpu_pkg.sv
source/cpu_decode.sv
source/cpu_alu.sv
source/cpu_multiply.sv
source/cpu_divide.sv
source/cpu_execute.sv
source/cpu_execute_top.sv
dv/execute_checker.sv
dv/tb_cpu_execute.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --assert -j 0
TOP       = tb_cpu_execute
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a listed source changes.
$(BUILD_DIR)/V%: $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$*

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
